// ==== logic/cpu_cfg.svh ====
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// datapath width
// shared by registers, bus, ALU and ports
`define CPU_DATA_W 32

// RAM address width
// 256 words behind MAR
`define CPU_MEM_AW 8

// immediate field C
// sign-extended up to the data width
`define CPU_IMM_W 19

// top of the opcode field
`define CPU_OP_MSB 31

`endif

// ==== logic/isaPkg.sv ====
package isaPkg;

    // instruction word layout
    //   opcode  bits 31..27
    //   ra      bits 26..23
    //   rb      bits 22..19
    //   rc      bits 18..15
    //   C       bits 18..0, sign-extended

    // 5-bit major opcodes
    typedef enum logic [4:0] {
        opLd   = 5'b00000,
        opSt   = 5'b00010,
        opAdd  = 5'b00011,
        opSub  = 5'b00100,
        opAnd  = 5'b01010,
        opOr   = 5'b01011,
        opAddi = 5'b01100,
        opNeg  = 5'b10000,
        opBrzr = 5'b10010,
        opBrnz = 5'b10011,
        opIn   = 5'b10110,
        opOut  = 5'b10111,
        opHalt = 5'b11011
    } opcodeT;

    // ALU functions, operand A is Y and operand B is the bus
    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluNeg = 3'd4
    } aluOpT;

endpackage

// ==== logic/ctrlPkg.sv ====
package ctrlPkg;

    // control sequencer states
    typedef enum logic [3:0] {
        sIdle   = 4'd0,
        sFetch0 = 4'd1,
        sFetch1 = 4'd2,
        sFetch2 = 4'd3,
        sExec1  = 4'd4,
        sExec2  = 4'd5,
        sExec3  = 4'd6,
        sExec4  = 4'd7,
        sHalt   = 4'd8
    } stateT;

    // who drives the shared bus this cycle
    typedef enum logic [2:0] {
        srcNone   = 3'd0,
        srcReg    = 3'd1,
        srcPc     = 3'd2,
        srcMdr    = 3'd3,
        srcZ      = 3'd4,
        srcInPort = 3'd5,
        srcImm    = 3'd6
    } busSrcT;

    // IR field that names the register
    typedef enum logic [1:0] {
        selRa = 2'd0,
        selRb = 2'd1,
        selRc = 2'd2
    } regSelT;

endpackage

// ==== logic/memoryUnit.sv ====
`include "cpu_cfg.svh"

module memoryUnit (
    input  logic                   clock,
    input  logic                   rstN,
    input  logic [`CPU_DATA_W-1:0] bus,
    input  logic                   marIn,
    input  logic                   mdrIn,
    input  logic                   memRead,
    input  logic                   memWrite,
    input  logic                   loadEn,
    input  logic [`CPU_MEM_AW-1:0] loadAddr,
    input  logic [`CPU_DATA_W-1:0] loadData,
    output logic [`CPU_DATA_W-1:0] mdrData
);

    logic [`CPU_DATA_W-1:0] ram [2**`CPU_MEM_AW];
    logic [`CPU_MEM_AW-1:0] mar;
    logic [`CPU_MEM_AW-1:0] memAddr;

    // address follows the bus while MAR loads
    // lets ld and st access RAM in the MAR cycle
    assign memAddr = marIn ? bus[`CPU_MEM_AW-1:0] : mar;

    always_ff @(posedge clock) begin
        if (!rstN) begin
            mar <= '0;
        end else if (marIn) begin
            mar <= bus[`CPU_MEM_AW-1:0];
        end
    end

    // load port wins over a store
    always_ff @(posedge clock) begin
        if (loadEn) begin
            ram[loadAddr] <= loadData;
        end else if (memWrite) begin
            ram[memAddr] <= mdrData;
        end
    end

    // synchronous read lands in MDR
    always_ff @(posedge clock) begin
        if (!rstN) begin
            mdrData <= '0;
        end else if (memRead) begin
            mdrData <= ram[memAddr];
        end else if (mdrIn) begin
            mdrData <= bus;
        end
    end

endmodule

// ==== logic/regBank.sv ====
`include "cpu_cfg.svh"

module regBank (
    input  ctrlPkg::busSrcT        busSrc,
    input  ctrlPkg::regSelT        regSel,
    input  logic                   clock,
    input  logic                   rstN,
    input  logic                   regIn,
    input  logic                   baseZero,
    input  logic                   pcIn,
    input  logic                   pcInc,
    input  logic                   pcClear,
    input  logic                   irIn,
    input  logic [`CPU_DATA_W-1:0] mdrData,
    input  logic [`CPU_DATA_W-1:0] zData,
    input  logic [`CPU_DATA_W-1:0] inPortData,
    output logic [`CPU_DATA_W-1:0] bus,
    output logic [`CPU_DATA_W-1:0] ir,
    output logic                   condMet
);

    logic [`CPU_DATA_W-1:0] regs [16];
    logic [`CPU_DATA_W-1:0] pc;
    logic [`CPU_DATA_W-1:0] regOut;
    logic [`CPU_DATA_W-1:0] cSext;
    logic [3:0]             regIdx;

    // pick ra, rb or rc out of the IR
    always_comb begin
        case (regSel)
            ctrlPkg::selRb: regIdx = ir[22:19];
            ctrlPkg::selRc: regIdx = ir[18:15];
            default:        regIdx = ir[26:23];
        endcase
    end

    // r0 reads as zero only as a base
    assign regOut = (baseZero && regIdx == 4'd0) ? '0 : regs[regIdx];

    assign cSext = {{(`CPU_DATA_W - `CPU_IMM_W){ir[`CPU_IMM_W-1]}}, ir[`CPU_IMM_W-1:0]};

    // bus multiplexer
    always_comb begin
        case (busSrc)
            ctrlPkg::srcReg:    bus = regOut;
            ctrlPkg::srcPc:     bus = pc;
            ctrlPkg::srcMdr:    bus = mdrData;
            ctrlPkg::srcZ:      bus = zData;
            ctrlPkg::srcInPort: bus = inPortData;
            ctrlPkg::srcImm:    bus = cSext;
            default:            bus = '0;
        endcase
    end

    // branch test on whatever sits on the bus
    assign condMet = (bus == '0);

    always_ff @(posedge clock) begin
        if (!rstN) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
            ir <= '0;
        end else begin
            if (regIn) begin
                regs[regIdx] <= bus;
            end
            if (irIn) begin
                ir <= bus;
            end
        end
    end

    // pcIn adds the branch offset to the incremented PC
    always_ff @(posedge clock) begin
        if (!rstN || pcClear) begin
            pc <= '0;
        end else if (pcIn) begin
            pc <= pc + bus;
        end else if (pcInc) begin
            pc <= pc + 1'b1;
        end
    end

endmodule

// ==== logic/aluUnit.sv ====
`include "cpu_cfg.svh"

module aluUnit (
    input  logic                   clock,
    input  logic                   rstN,
    input  logic [`CPU_DATA_W-1:0] bus,
    input  logic                   yIn,
    input  logic                   zIn,
    input  isaPkg::aluOpT          aluOp,
    output logic [`CPU_DATA_W-1:0] zData
);

    logic [`CPU_DATA_W-1:0] y;
    logic [`CPU_DATA_W-1:0] result;

    // operand A holder
    always_ff @(posedge clock) begin
        if (!rstN) begin
            y <= '0;
        end else if (yIn) begin
            y <= bus;
        end
    end

    // A is Y, B is the bus
    always_comb begin
        case (aluOp)
            isaPkg::aluAdd: result = y + bus;
            isaPkg::aluSub: result = y - bus;
            isaPkg::aluAnd: result = y & bus;
            isaPkg::aluOr:  result = y | bus;
            // two's complement of B alone
            isaPkg::aluNeg: result = ~bus + 1'b1;
            default:        result = '0;
        endcase
    end

    // result register
    always_ff @(posedge clock) begin
        if (!rstN) begin
            zData <= '0;
        end else if (zIn) begin
            zData <= result;
        end
    end

endmodule

// ==== logic/controlUnit.sv ====
`include "cpu_cfg.svh"

module controlUnit (
    input  logic                   clock,
    input  logic                   rstN,
    input  logic                   start,
    input  logic [`CPU_DATA_W-1:0] ir,
    input  logic                   condMet,
    output ctrlPkg::busSrcT        busSrc,
    output ctrlPkg::regSelT        regSel,
    output logic                   regIn,
    output logic                   baseZero,
    output logic                   pcIn,
    output logic                   pcInc,
    output logic                   pcClear,
    output logic                   irIn,
    output logic                   yIn,
    output logic                   zIn,
    output logic                   marIn,
    output logic                   mdrIn,
    output logic                   memRead,
    output logic                   memWrite,
    output logic                   outIn,
    output logic                   halted,
    output isaPkg::aluOpT          aluOp
);

    ctrlPkg::stateT state;
    ctrlPkg::stateT nextState;
    isaPkg::opcodeT opcode;
    isaPkg::aluOpT  aluFn;
    logic           isAluRr;
    logic           takeBranch;

    assign opcode = isaPkg::opcodeT'(ir[`CPU_OP_MSB -: 5]);
    assign halted = (state == ctrlPkg::sHalt);

    // register-register ALU group and its function
    always_comb begin
        isAluRr = 1'b1;
        case (opcode)
            isaPkg::opSub: aluFn = isaPkg::aluSub;
            isaPkg::opAnd: aluFn = isaPkg::aluAnd;
            isaPkg::opOr:  aluFn = isaPkg::aluOr;
            isaPkg::opAdd: aluFn = isaPkg::aluAdd;
            default: begin
                aluFn   = isaPkg::aluAdd;
                isAluRr = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            state      <= ctrlPkg::sIdle;
            takeBranch <= 1'b0;
        end else begin
            state <= nextState;
            // ra is on the bus in the first branch step
            if (state == ctrlPkg::sExec1) begin
                takeBranch <= (opcode == isaPkg::opBrzr) ? condMet : !condMet;
            end
        end
    end

    // strobes come from state and opcode only
    always_comb begin
        nextState = state;
        busSrc    = ctrlPkg::srcNone;
        regSel    = ctrlPkg::selRa;
        aluOp     = isaPkg::aluAdd;
        {regIn, baseZero, pcIn, pcInc, pcClear, irIn} = '0;
        {yIn, zIn, marIn, mdrIn, memRead, memWrite, outIn} = '0;
        case (state)
            ctrlPkg::sIdle: begin
                if (start) begin
                    pcClear   = 1'b1;
                    nextState = ctrlPkg::sFetch0;
                end
            end
            // MAR from PC, PC steps
            ctrlPkg::sFetch0: begin
                busSrc    = ctrlPkg::srcPc;
                marIn     = 1'b1;
                pcInc     = 1'b1;
                nextState = ctrlPkg::sFetch1;
            end
            ctrlPkg::sFetch1: begin
                memRead   = 1'b1;
                nextState = ctrlPkg::sFetch2;
            end
            ctrlPkg::sFetch2: begin
                busSrc    = ctrlPkg::srcMdr;
                irIn      = 1'b1;
                nextState = ctrlPkg::sExec1;
            end
            ctrlPkg::sExec1: begin
                nextState = ctrlPkg::sExec2;
                busSrc    = ctrlPkg::srcReg;
                case (opcode)
                    isaPkg::opAdd, isaPkg::opSub, isaPkg::opAnd,
                    isaPkg::opOr, isaPkg::opAddi: begin
                        regSel = ctrlPkg::selRb;
                        yIn    = 1'b1;
                    end
                    // neg skips Y and goes straight to writeback
                    isaPkg::opNeg: begin
                        regSel    = ctrlPkg::selRb;
                        aluOp     = isaPkg::aluNeg;
                        zIn       = 1'b1;
                        nextState = ctrlPkg::sExec3;
                    end
                    isaPkg::opLd: begin
                        regSel   = ctrlPkg::selRb;
                        baseZero = 1'b1;
                        yIn      = 1'b1;
                    end
                    // store data parked in MDR first
                    isaPkg::opSt: mdrIn = 1'b1;
                    isaPkg::opBrzr, isaPkg::opBrnz: ;
                    isaPkg::opIn: begin
                        busSrc    = ctrlPkg::srcInPort;
                        regIn     = 1'b1;
                        nextState = ctrlPkg::sFetch0;
                    end
                    isaPkg::opOut: begin
                        outIn     = 1'b1;
                        nextState = ctrlPkg::sFetch0;
                    end
                    isaPkg::opHalt: nextState = ctrlPkg::sHalt;
                    default: nextState = ctrlPkg::sFetch0;
                endcase
            end
            ctrlPkg::sExec2: begin
                nextState = ctrlPkg::sExec3;
                if (isAluRr) begin
                    busSrc = ctrlPkg::srcReg;
                    regSel = ctrlPkg::selRc;
                    aluOp  = aluFn;
                    zIn    = 1'b1;
                end else if (opcode == isaPkg::opAddi || opcode == isaPkg::opLd) begin
                    busSrc = ctrlPkg::srcImm;
                    zIn    = 1'b1;
                end else if (opcode == isaPkg::opSt) begin
                    busSrc   = ctrlPkg::srcReg;
                    regSel   = ctrlPkg::selRb;
                    baseZero = 1'b1;
                    yIn      = 1'b1;
                end else begin
                    // branch offset onto the PC when taken
                    busSrc    = ctrlPkg::srcImm;
                    pcIn      = takeBranch;
                    nextState = ctrlPkg::sFetch0;
                end
            end
            ctrlPkg::sExec3: begin
                nextState = ctrlPkg::sFetch0;
                if (opcode == isaPkg::opLd) begin
                    busSrc    = ctrlPkg::srcZ;
                    marIn     = 1'b1;
                    memRead   = 1'b1;
                    nextState = ctrlPkg::sExec4;
                end else if (opcode == isaPkg::opSt) begin
                    busSrc    = ctrlPkg::srcImm;
                    zIn       = 1'b1;
                    nextState = ctrlPkg::sExec4;
                end else begin
                    // ALU writeback into ra
                    busSrc = ctrlPkg::srcZ;
                    regIn  = 1'b1;
                end
            end
            ctrlPkg::sExec4: begin
                nextState = ctrlPkg::sFetch0;
                if (opcode == isaPkg::opLd) begin
                    busSrc = ctrlPkg::srcMdr;
                    regIn  = 1'b1;
                end else begin
                    busSrc   = ctrlPkg::srcZ;
                    marIn    = 1'b1;
                    memWrite = 1'b1;
                end
            end
            // sHalt holds until reset
            default: ;
        endcase
    end

endmodule

// ==== logic/ioPorts.sv ====
`include "cpu_cfg.svh"

module ioPorts (
    input  logic                   clock,
    input  logic                   rstN,
    input  logic [`CPU_DATA_W-1:0] inData,
    input  logic                   inStrobe,
    input  logic [`CPU_DATA_W-1:0] bus,
    input  logic                   outIn,
    output logic [`CPU_DATA_W-1:0] inPortData,
    output logic [`CPU_DATA_W-1:0] outData,
    output logic                   outStrobe
);

    always_ff @(posedge clock) begin
        if (!rstN) begin
            inPortData <= '0;
            outData    <= '0;
            outStrobe  <= 1'b0;
        end else begin
            // device side latch
            if (inStrobe) begin
                inPortData <= inData;
            end
            if (outIn) begin
                outData <= bus;
            end
            // marks the cycle after outData changes
            outStrobe <= outIn;
        end
    end

endmodule

// ==== logic/cpuTop.sv ====
`include "cpu_cfg.svh"

module cpuTop (
    input  logic                   clock,
    input  logic                   rstN,
    input  logic                   start,
    input  logic                   loadEn,
    input  logic [`CPU_MEM_AW-1:0] loadAddr,
    input  logic [`CPU_DATA_W-1:0] loadData,
    input  logic [`CPU_DATA_W-1:0] inData,
    input  logic                   inStrobe,
    output logic [`CPU_DATA_W-1:0] outData,
    output logic                   outStrobe,
    output logic                   halted
);

    // shared bus and its sources
    logic [`CPU_DATA_W-1:0] bus;
    logic [`CPU_DATA_W-1:0] mdrData;
    logic [`CPU_DATA_W-1:0] zData;
    logic [`CPU_DATA_W-1:0] inPortData;
    logic [`CPU_DATA_W-1:0] ir;
    logic                   condMet;

    // control strobes
    ctrlPkg::busSrcT busSrc;
    ctrlPkg::regSelT regSel;
    isaPkg::aluOpT   aluOp;
    logic regIn, baseZero, pcIn, pcInc, pcClear, irIn;
    logic yIn, zIn, marIn, mdrIn, memRead, memWrite, outIn;

    memoryUnit memory (.clock(clock), .rstN(rstN), .bus(bus), .marIn(marIn),
        .mdrIn(mdrIn), .memRead(memRead), .memWrite(memWrite), .loadEn(loadEn),
        .loadAddr(loadAddr), .loadData(loadData), .mdrData(mdrData));

    ioPorts ports (.clock(clock), .rstN(rstN), .inData(inData), .inStrobe(inStrobe),
        .bus(bus), .outIn(outIn), .inPortData(inPortData), .outData(outData),
        .outStrobe(outStrobe));

    regBank registers (.clock(clock), .rstN(rstN), .busSrc(busSrc), .regSel(regSel),
        .regIn(regIn), .baseZero(baseZero), .pcIn(pcIn), .pcInc(pcInc),
        .pcClear(pcClear), .irIn(irIn), .mdrData(mdrData), .zData(zData),
        .inPortData(inPortData), .bus(bus), .ir(ir), .condMet(condMet));

    aluUnit alu (.clock(clock), .rstN(rstN), .bus(bus), .yIn(yIn), .zIn(zIn),
        .aluOp(aluOp), .zData(zData));

    controlUnit control (.clock(clock), .rstN(rstN), .start(start), .ir(ir),
        .condMet(condMet), .busSrc(busSrc), .regSel(regSel), .regIn(regIn),
        .baseZero(baseZero), .pcIn(pcIn), .pcInc(pcInc), .pcClear(pcClear),
        .irIn(irIn), .yIn(yIn), .zIn(zIn), .marIn(marIn), .mdrIn(mdrIn),
        .memRead(memRead), .memWrite(memWrite), .outIn(outIn), .halted(halted),
        .aluOp(aluOp));

endmodule

// ==== bench/cpuTb.sv ====
`include "cpu_cfg.svh"

module cpuTb;

    timeunit 1ns;
    timeprecision 100ps;

    // 35 instructions at up to 7 cycles plus loading leave a wide margin
    localparam int timeoutCycles = 2000;

    logic                   clock;
    logic                   rstN;
    logic                   start;
    logic                   loadEn;
    logic [`CPU_MEM_AW-1:0] loadAddr;
    logic [`CPU_DATA_W-1:0] loadData;
    logic [`CPU_DATA_W-1:0] inData;
    logic                   inStrobe;
    logic [`CPU_DATA_W-1:0] outData;
    logic                   outStrobe;
    logic                   halted;

    // program image and expected out values in program order
    logic [`CPU_DATA_W-1:0] prog [$];
    logic [`CPU_DATA_W-1:0] expQ [$];
    logic [`CPU_DATA_W-1:0] expHead = '0;
    logic [`CPU_DATA_W-1:0] lcgState;
    logic [`CPU_DATA_W-1:0] inValue;
    bit                     expPending = 1'b0;
    bit                     outSeen = 1'b0;
    int                     cycleCount = 0;

    cpuTop UUT (
        .clock(clock), .rstN(rstN), .start(start), .loadEn(loadEn),
        .loadAddr(loadAddr), .loadData(loadData), .inData(inData),
        .inStrobe(inStrobe), .outData(outData), .outStrobe(outStrobe),
        .halted(halted)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    task automatic abortRun();
        $display("TESTS FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic valueError(input string name, input logic [`CPU_DATA_W-1:0] expected,
                              input logic [`CPU_DATA_W-1:0] actual);
        $display("ERR time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
        abortRun();
    endtask

    task automatic failWith(input string msg);
        $display("%0t: %s", $time, msg);
        abortRun();
    endtask

    // LCG with the Numerical Recipes constants
    function automatic logic [`CPU_DATA_W-1:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // opcode, ra, rb, then rc or C in the low 19 bits
    task automatic emit(input isaPkg::opcodeT op, input int ra, input int rb, input int field);
        prog.push_back({op, 4'(ra), 4'(rb), `CPU_IMM_W'(field)});
    endtask

    task automatic emitRrr(input isaPkg::opcodeT op, input int ra, input int rb, input int rc);
        emit(op, ra, rb, rc << 15);
    endtask

    task automatic buildProgram();
        logic [`CPU_DATA_W-1:0] a;
        int                     off;
        int                     absAddr;
        // a kept odd so its sign-extended C is never zero
        a = nextRand() | 32'd1;
        off = int'(nextRand() & 32'h7);
        absAddr = 'hC0 + int'(nextRand() & 32'hF);
        emit(isaPkg::opAddi, 1, 0, int'(a));
        emit(isaPkg::opAddi, 2, 0, int'(nextRand()));
        // ALU group with each result sent out
        emitRrr(isaPkg::opAdd, 3, 1, 2);
        emit(isaPkg::opOut, 3, 0, 0);
        emitRrr(isaPkg::opSub, 4, 1, 2);
        emit(isaPkg::opOut, 4, 0, 0);
        emitRrr(isaPkg::opAnd, 5, 1, 2);
        emit(isaPkg::opOut, 5, 0, 0);
        emitRrr(isaPkg::opOr, 6, 1, 2);
        emit(isaPkg::opOut, 6, 0, 0);
        emit(isaPkg::opNeg, 7, 1, 0);
        emit(isaPkg::opOut, 7, 0, 0);
        // st then ld through a based address
        emit(isaPkg::opAddi, 8, 0, 'h90);
        emit(isaPkg::opAddi, 9, 0, int'(nextRand()));
        // odd value in r0 that a base read has to ignore
        emit(isaPkg::opAddi, 0, 0, int'(nextRand() | 32'd1));
        emit(isaPkg::opSt, 9, 8, off);
        // same word read back with r0 as base
        emit(isaPkg::opLd, 10, 0, 'h90 + off);
        emit(isaPkg::opOut, 10, 0, 0);
        // absolute store through r0 read back through r8
        emit(isaPkg::opSt, 7, 0, absAddr);
        emit(isaPkg::opLd, 11, 8, absAddr - 'h90);
        emit(isaPkg::opOut, 11, 0, 0);
        emit(isaPkg::opIn, 12, 0, 0);
        emit(isaPkg::opOut, 12, 0, 0);
        // markers and a forced zero in r14
        emit(isaPkg::opAddi, 13, 0, int'(nextRand() | 32'd1));
        emit(isaPkg::opAddi, 15, 13, 1);
        emitRrr(isaPkg::opSub, 14, 1, 1);
        // each branch skips exactly one out when taken
        emit(isaPkg::opBrzr, 14, 0, 1);
        emit(isaPkg::opOut, 13, 0, 0);
        emit(isaPkg::opBrzr, 1, 0, 1);
        emit(isaPkg::opOut, 13, 0, 0);
        emit(isaPkg::opBrnz, 1, 0, 1);
        emit(isaPkg::opOut, 13, 0, 0);
        emit(isaPkg::opBrnz, 14, 0, 1);
        emit(isaPkg::opOut, 15, 0, 0);
        emit(isaPkg::opHalt, 0, 0, 0);
    endtask

    // instruction-level model that walks the image and queues every out value
    task automatic runModel(input logic [`CPU_DATA_W-1:0] portValue);
        logic [`CPU_DATA_W-1:0] modelReg [16];
        logic [`CPU_DATA_W-1:0] modelMem [2**`CPU_MEM_AW];
        logic [`CPU_DATA_W-1:0] word;
        logic [`CPU_DATA_W-1:0] imm;
        logic [`CPU_DATA_W-1:0] base;
        logic [`CPU_DATA_W-1:0] pc;
        logic [`CPU_MEM_AW-1:0] addr;
        logic [3:0]             ra;
        logic [3:0]             rb;
        logic [3:0]             rc;
        int                     steps;
        bit                     stopped;
        foreach (modelReg[i]) begin
            modelReg[i] = '0;
        end
        foreach (modelMem[i]) begin
            modelMem[i] = '0;
        end
        foreach (prog[i]) begin
            modelMem[i] = prog[i];
        end
        pc = '0;
        steps = 0;
        stopped = 1'b0;
        while (!stopped && steps < 256) begin
            word = modelMem[pc[`CPU_MEM_AW-1:0]];
            pc = pc + 1;
            steps++;
            ra = word[26:23];
            rb = word[22:19];
            rc = word[18:15];
            imm = `CPU_DATA_W'($signed(word[`CPU_IMM_W-1:0]));
            // r0 as a base counts as zero
            base = (rb == 4'd0) ? '0 : modelReg[rb];
            addr = `CPU_MEM_AW'(base + imm);
            case (isaPkg::opcodeT'(word[31:27]))
                isaPkg::opAdd:  modelReg[ra] = modelReg[rb] + modelReg[rc];
                isaPkg::opSub:  modelReg[ra] = modelReg[rb] - modelReg[rc];
                isaPkg::opAnd:  modelReg[ra] = modelReg[rb] & modelReg[rc];
                isaPkg::opOr:   modelReg[ra] = modelReg[rb] | modelReg[rc];
                isaPkg::opNeg:  modelReg[ra] = -modelReg[rb];
                isaPkg::opAddi: modelReg[ra] = modelReg[rb] + imm;
                isaPkg::opLd:   modelReg[ra] = modelMem[addr];
                isaPkg::opSt:   modelMem[addr] = modelReg[ra];
                isaPkg::opBrzr: begin
                    if (modelReg[ra] == '0) begin
                        pc = pc + imm;
                    end
                end
                isaPkg::opBrnz: begin
                    if (modelReg[ra] != '0) begin
                        pc = pc + imm;
                    end
                end
                isaPkg::opIn:   modelReg[ra] = portValue;
                isaPkg::opOut:  expQ.push_back(modelReg[ra]);
                isaPkg::opHalt: stopped = 1'b1;
                default: ;
            endcase
        end
    endtask

    // one word per cycle through the load port
    task automatic loadProgram();
        foreach (prog[i]) begin
            @(posedge clock);
            #2;
            loadEn = 1'b1;
            loadAddr = `CPU_MEM_AW'(i);
            loadData = prog[i];
        end
        @(posedge clock);
        #2;
        loadEn = 1'b0;
    endtask

    task automatic latchInput(input logic [`CPU_DATA_W-1:0] value);
        @(posedge clock);
        #2;
        inData = value;
        inStrobe = 1'b1;
        @(posedge clock);
        #2;
        inStrobe = 1'b0;
    endtask

    task automatic pulseStart();
        @(posedge clock);
        #2;
        start = 1'b1;
        @(posedge clock);
        #2;
        start = 1'b0;
    endtask

    // sees the old strobe value just as the assertions sample it
    always @(posedge clock) begin
        if (rstN && outStrobe) begin
            outSeen <= 1'b1;
            if (expQ.size() != 0) begin
                void'(expQ.pop_front());
            end
        end
        if (expQ.size() != 0) begin
            expHead <= expQ[0];
        end else begin
            expHead <= '0;
        end
        expPending <= (expQ.size() != 0);
    end

    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            failWith("timeout, the program never reached halt");
        end
    end

    outValueCheck: assert property (@(posedge clock) disable iff (!rstN)
        outStrobe |-> (outData == expHead))
        else valueError("outData", $sampled(expHead), $sampled(outData));

    strobeExpectedCheck: assert property (@(posedge clock) disable iff (!rstN)
        outStrobe |-> expPending)
        else failWith("outStrobe seen with no out value left in the model");

    quietBeforeOutCheck: assert property (@(posedge clock) disable iff (!rstN)
        !outSeen |-> (outStrobe || outData == '0))
        else valueError("outData", '0, $sampled(outData));

    noEarlyHaltCheck: assert property (@(posedge clock) disable iff (!rstN)
        !outSeen |-> !halted)
        else failWith("halted rose before any out instruction");

    haltHoldCheck: assert property (@(posedge clock) disable iff (!rstN)
        halted |=> halted)
        else valueError("halted", 1, $sampled(halted));

    quietAfterHaltCheck: assert property (@(posedge clock) disable iff (!rstN)
        halted |-> !outStrobe)
        else failWith("outStrobe pulsed after halt");

    haltAfterAllCheck: assert property (@(posedge clock) disable iff (!rstN)
        halted |-> !expPending)
        else failWith("halted while out values were still expected");

    initial begin
        rstN = 1'b0;
        start = 1'b0;
        loadEn = 1'b0;
        loadAddr = '0;
        loadData = '0;
        inData = '0;
        inStrobe = 1'b0;
        lcgState = 32'd99;
        inValue = nextRand();
        buildProgram();
        runModel(inValue);
        repeat (2) @(posedge clock);
        #2;
        rstN = 1'b1;
        @(negedge clock);
        idleAfterReset: assert (!outStrobe && !halted && outData == '0)
            else failWith("outputs not quiet after reset");
        loadProgram();
        latchInput(inValue);
        pulseStart();
        while (!halted) begin
            @(negedge clock);
        end
        // a few idle cycles for stray strobes after halt
        repeat (8) @(negedge clock);
        if (!expPending && halted) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("%0t: run ended with %0d out values never seen", $time, expQ.size());
            abortRun();
        end
    end

endmodule

// ==== flist.f ====
+incdir+logic
logic/isaPkg.sv
logic/ctrlPkg.sv
logic/memoryUnit.sv
logic/regBank.sv
logic/aluUnit.sv
logic/controlUnit.sv
logic/ioPorts.sv
logic/cpuTop.sv
bench/cpuTb.sv
